// File: common/uart_pkg.sv
package uart_pkg;

    // Master-to-slave half of the APB port
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Status word, zero-extended on read
    typedef struct packed {
        logic rx_full;
        logic tx_empty;
        logic tx_full;
        logic rx_empty;
    } uart_status_t;

    // Register offsets, decoded on bits 3:2
    localparam logic [3:0] ADDR_STATUS  = 4'h0;
    localparam logic [3:0] ADDR_SCRATCH = 4'h4;
    localparam logic [3:0] ADDR_TXDATA  = 4'h8;
    localparam logic [3:0] ADDR_RXDATA  = 4'hC;

    // 8N1 frame with 16x oversampling
    localparam int OVERSAMPLE = 16;
    localparam int DATA_BITS  = 8;

endpackage

// File: source/baud_tick_gen.sv
`timescale 1ns/10ps

module baud_tick_gen #(
    parameter int TICK_DIV = 651
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_W'(TICK_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;
        end
    end

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic       pop,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic       empty,
    output logic       full
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wptr;
    logic [AW-1:0] rptr;
    logic          do_push;
    logic          do_pop;

    // Overflow pushes and underflow pops are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign rdata = mem[rptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            // Push and pop together keep the count, so the flags hold
            if (do_push && !do_pop) begin
                empty <= 1'b0;
                full  <= (AW'(wptr + 1'b1) == rptr);
            end else if (do_pop && !do_push) begin
                full  <= 1'b0;
                empty <= (AW'(rptr + 1'b1) == wptr);
            end
        end
    end

endmodule

// File: uart/uart_apb_regs.sv
`timescale 1ns/10ps

module uart_apb_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_pkg::apb_req_t     apb_req,
    output logic [31:0]            prdata,
    output logic                   pready,
    input  uart_pkg::uart_status_t status,
    input  logic [7:0]             rx_rdata,
    output logic                   tx_push,
    output logic [7:0]             tx_wdata,
    output logic                   rx_pop
);

    import uart_pkg::*;

    localparam logic [1:0] SEL_STATUS  = ADDR_STATUS[3:2];
    localparam logic [1:0] SEL_SCRATCH = ADDR_SCRATCH[3:2];
    localparam logic [1:0] SEL_TXDATA  = ADDR_TXDATA[3:2];
    localparam logic [1:0] SEL_RXDATA  = ADDR_RXDATA[3:2];

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESPOND,
        ST_RECOVER
    } state_t;

    state_t      state;
    logic        access;
    logic [1:0]  sel;
    logic [31:0] scratch;
    logic [7:0]  last_tx;

    // First access cycle, only accepted when idle
    assign access = (state == ST_IDLE) && apb_req.psel && apb_req.penable;
    assign sel    = apb_req.paddr[3:2];

    assign tx_wdata = last_tx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            pready  <= 1'b0;
            tx_push <= 1'b0;
            rx_pop  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (access) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: state <= ST_RECOVER;
                default:    state <= ST_IDLE;
            endcase
            pready  <= access;
            tx_push <= access && apb_req.pwrite && (sel == SEL_TXDATA);
            rx_pop  <= access && !apb_req.pwrite && (sel == SEL_RXDATA);
        end
    end

    // Register writes and read data capture
    always_ff @(posedge clk) begin
        if (access) begin
            if (apb_req.pwrite) begin
                if (sel == SEL_SCRATCH) begin
                    scratch <= apb_req.pwdata;
                end
                if (sel == SEL_TXDATA) begin
                    last_tx <= apb_req.pwdata[7:0];
                end
            end else begin
                case (sel)
                    SEL_STATUS:  prdata <= 32'(status);
                    SEL_SCRATCH: prdata <= scratch;
                    SEL_TXDATA:  prdata <= {24'd0, last_tx};
                    default:     prdata <= {24'd0, rx_rdata};
                endcase
            end
        end
    end

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       tx_avail,
    input  logic [7:0] tx_data,
    output logic       tx_pop,
    output logic       tx
);

    import uart_pkg::*;

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int BIT_W  = $clog2(DATA_BITS);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ALIGN,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t                 state;
    logic [TICK_W-1:0]      tick_cnt;
    logic [BIT_W-1:0]       bit_cnt;
    logic [DATA_BITS-1:0]   shift;
    logic                   bit_end;

    assign bit_end = tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_pop   <= 1'b0;
            tx       <= 1'b1;
        end else begin
            tx_pop <= 1'b0;
            if (tick && state != ST_IDLE && state != ST_ALIGN) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    tx <= 1'b1;
                    if (tx_avail) begin
                        tx_pop <= 1'b1;
                        state  <= ST_ALIGN;
                    end
                end
                ST_ALIGN: begin
                    // Start bit lines up with the tick grid
                    if (tick) begin
                        tick_cnt <= '0;
                        tx       <= 1'b0;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        tx      <= shift[0];
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            tx    <= 1'b1;
                            state <= ST_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift[0];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Shift register always holds the bits not yet on the line
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tx_avail) begin
            shift <= tx_data;
        end else if (bit_end && (state == ST_START || state == ST_DATA)) begin
            shift <= {1'b0, shift[DATA_BITS-1:1]};
        end
    end

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       rx,
    output logic       rx_push,
    output logic [7:0] rx_wdata
);

    import uart_pkg::*;

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int BIT_W  = $clog2(DATA_BITS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t            state;
    logic              rx_meta;
    logic              rx_sync;
    logic [TICK_W-1:0] tick_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic              mid_start;
    logic              bit_end;

    assign mid_start = tick && (tick_cnt == TICK_W'(OVERSAMPLE / 2 - 1));
    assign bit_end   = tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_push  <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_push <= 1'b0;
            if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    // Line back high at mid start bit means a glitch
                    if (mid_start) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            state <= ST_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        rx_push <= rx_sync;
                        state   <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == ST_DATA && bit_end) begin
            rx_wdata <= {rx_sync, rx_wdata[7:1]};
        end
    end

endmodule

// File: uart/uart_apb_periph.sv
`timescale 1ns/10ps

module uart_apb_periph #(
    parameter int TICK_DIV   = 651,
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  uart_pkg::apb_req_t apb_req,
    output logic [31:0]        prdata,
    output logic               pready,
    input  logic               rx,
    output logic               tx
);

    import uart_pkg::*;

    uart_status_t status;
    logic         tick;
    logic         tx_push;
    logic         tx_pop;
    logic [7:0]   tx_wdata;
    logic [7:0]   tx_head;
    logic         tx_empty;
    logic         tx_full;
    logic         rx_push;
    logic         rx_pop;
    logic [7:0]   rx_wdata;
    logic [7:0]   rx_head;
    logic         rx_empty;
    logic         rx_full;

    assign status = '{
        rx_full:  rx_full,
        tx_empty: tx_empty,
        tx_full:  tx_full,
        rx_empty: rx_empty
    };

    uart_apb_regs regs_i (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .prdata   (prdata),
        .pready   (pready),
        .status   (status),
        .rx_rdata (rx_head),
        .tx_push  (tx_push),
        .tx_wdata (tx_wdata),
        .rx_pop   (rx_pop)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .pop   (tx_pop),
        .wdata (tx_wdata),
        .rdata (tx_head),
        .empty (tx_empty),
        .full  (tx_full)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_push),
        .pop   (rx_pop),
        .wdata (rx_wdata),
        .rdata (rx_head),
        .empty (rx_empty),
        .full  (rx_full)
    );

    uart_tx tx_i (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_avail (!tx_empty),
        .tx_data  (tx_head),
        .tx_pop   (tx_pop),
        .tx       (tx)
    );

    uart_rx rx_i (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .rx       (rx),
        .rx_push  (rx_push),
        .rx_wdata (rx_wdata)
    );

    baud_tick_gen #(.TICK_DIV(TICK_DIV)) tick_i (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

endmodule

// File: tests/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;

    import uart_pkg::*;

    localparam int TB_TICK_DIV  = 4;
    localparam int BIT_CLOCKS   = OVERSAMPLE * TB_TICK_DIV;
    localparam int FRAME_CYCLES = 700;
    localparam int APB_CYCLES   = 3;
    localparam int MAX_POLLS    = 100;

    typedef enum logic [2:0] {
        K_APB_WRITE,
        K_APB_READ,
        K_SEND_FRAME,
        K_EXPECT_FRAME,
        K_WAIT_STATUS,
        K_GLITCH
    } kind_t;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    logic [31:0] prdata;
    logic        pready;
    logic        rx;
    logic        tx;

    // Test table, one entry per index
    string       t_name  [$];
    kind_t       t_kind  [$];
    logic [31:0] t_arg   [$];
    logic [31:0] t_value [$];

    // Frames seen on tx as {stop, data}
    logic [8:0]  tx_frames [$];

    logic [31:0] rd_word;
    logic [31:0] scratch_word;
    logic [7:0]  tx_bytes [4];
    logic [7:0]  rx_bytes [5];
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          cost_total;

    uart_apb_periph #(
        .TICK_DIV   (TB_TICK_DIV),
        .FIFO_DEPTH (4)
    ) uart_apb_periph_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .rx      (rx),
        .tx      (tx)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_status(input string name, input uart_status_t exp,
                                input uart_status_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected status %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp,
                              input logic [7:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic add_entry(input string name, input kind_t kind,
                             input logic [31:0] arg, input logic [31:0] value);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_arg.push_back(arg);
        t_value.push_back(value);
    endtask

    function automatic int entry_cost(input kind_t kind);
        if (kind == K_APB_WRITE || kind == K_APB_READ) begin
            return APB_CYCLES;
        end
        return FRAME_CYCLES;
    endfunction

    // Setup, access, then hold until pready
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        waited = 0;
        @(posedge clk);
        #1;
        while (!pready) begin
            waited++;
            if (waited > 4) begin
                $display("ERROR: pready never rose for access to offset %h", addr);
                stop_run();
            end
            @(posedge clk);
            #1;
        end
        rdata = prdata;
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    // 8N1 frame sent LSB first
    task automatic send_frame(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #2;
            rx = bits[i];
            repeat (BIT_CLOCKS - 1) @(posedge clk);
        end
    endtask

    task automatic send_glitch(input logic [31:0] clocks);
        @(posedge clk);
        #2;
        rx = 1'b0;
        repeat (clocks) @(posedge clk);
        #2;
        rx = 1'b1;
        // Long enough for a false frame to land in the FIFO
        repeat (FRAME_CYCLES) @(posedge clk);
    endtask

    task automatic expect_frame(input string name, input logic [7:0] exp);
        logic [8:0] frame;
        int         waited;
        waited = 0;
        while (tx_frames.size() == 0) begin
            if (waited >= 2 * FRAME_CYCLES) begin
                $display("ERROR: no frame appeared on tx for %s", name);
                stop_run();
            end
            @(posedge clk);
            waited++;
        end
        frame = tx_frames.pop_front();
        check_byte(name, exp, frame[7:0]);
        if (frame[8] !== 1'b1) begin
            $display("FAIL %s: expected stop bit 1, actual %b", name, frame[8]);
            stop_run();
        end
    endtask

    task automatic wait_status(input string name, input logic [3:0] mask,
                               input logic [3:0] want);
        logic [31:0] rd;
        int          polls;
        polls = 0;
        apb_access(1'b0, ADDR_STATUS, 32'd0, rd);
        while ((rd[3:0] & mask) != want) begin
            polls++;
            if (polls >= MAX_POLLS) begin
                $display("ERROR: %s gave up after %0d status polls", name, polls);
                stop_run();
            end
            apb_access(1'b0, ADDR_STATUS, 32'd0, rd);
        end
    endtask

    // Sample tx mid-bit from each falling start edge
    initial begin : tx_monitor
        logic [7:0] data;
        logic       stop;
        @(negedge rst);
        forever begin
            @(negedge tx);
            repeat (BIT_CLOCKS / 2) @(posedge clk);
            #1;
            if (tx !== 1'b0) begin
                $display("ERROR: start bit on tx did not stay low to mid-bit");
                stop_run();
            end
            for (int i = 0; i < DATA_BITS; i++) begin
                repeat (BIT_CLOCKS) @(posedge clk);
                #1;
                data[i] = tx;
            end
            repeat (BIT_CLOCKS) @(posedge clk);
            #1;
            stop = tx;
            tx_frames.push_back({stop, data});
        end
    end

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        apb_req = '0;
        rx      = 1'b1;

        scratch_word = $urandom(32'h04e36806);
        for (int i = 0; i < 4; i++) begin
            tx_bytes[i] = 8'($urandom);
        end
        for (int i = 0; i < 5; i++) begin
            rx_bytes[i] = 8'($urandom);
        end

        add_entry("reset_status", K_APB_READ, ADDR_STATUS, 32'h5);
        add_entry("scratch_write", K_APB_WRITE, ADDR_SCRATCH, scratch_word);
        add_entry("scratch_read", K_APB_READ, ADDR_SCRATCH, scratch_word);
        add_entry("rxdata_write", K_APB_WRITE, ADDR_RXDATA, ~scratch_word);
        add_entry("scratch_hold", K_APB_READ, ADDR_SCRATCH, scratch_word);
        add_entry("status_hold", K_APB_READ, ADDR_STATUS, 32'h5);
        // Upper bits of a TX write carry noise and must be ignored
        for (int i = 0; i < 4; i++) begin
            add_entry($sformatf("tx_write_%0d", i), K_APB_WRITE, ADDR_TXDATA,
                      {24'($urandom), tx_bytes[i]});
        end
        add_entry("tx_last", K_APB_READ, ADDR_TXDATA, {24'd0, tx_bytes[3]});
        for (int i = 0; i < 4; i++) begin
            add_entry($sformatf("tx_frame_%0d", i), K_EXPECT_FRAME, 32'd0,
                      {24'd0, tx_bytes[i]});
        end
        add_entry("tx_done_status", K_APB_READ, ADDR_STATUS, 32'h5);
        add_entry("rx_frame", K_SEND_FRAME, {24'd0, rx_bytes[0]}, 32'd0);
        add_entry("rx_wait", K_WAIT_STATUS, 32'h1, 32'h0);
        add_entry("rx_read", K_APB_READ, ADDR_RXDATA, {24'd0, rx_bytes[0]});
        add_entry("rx_empty_again", K_APB_READ, ADDR_STATUS, 32'h5);
        for (int i = 0; i < 5; i++) begin
            add_entry($sformatf("ovf_frame_%0d", i), K_SEND_FRAME,
                      {24'd0, rx_bytes[i]}, 32'd0);
        end
        add_entry("ovf_wait_full", K_WAIT_STATUS, 32'h8, 32'h8);
        add_entry("ovf_status", K_APB_READ, ADDR_STATUS, 32'hC);
        for (int i = 0; i < 4; i++) begin
            add_entry($sformatf("ovf_read_%0d", i), K_APB_READ, ADDR_RXDATA,
                      {24'd0, rx_bytes[i]});
        end
        add_entry("ovf_drained", K_APB_READ, ADDR_STATUS, 32'h5);
        // 16 clocks is 4 ticks and ends well before mid start bit
        add_entry("glitch", K_GLITCH, 32'd16, 32'd0);
        add_entry("glitch_status", K_APB_READ, ADDR_STATUS, 32'h5);

        cost_total = 0;
        for (int i = 0; i < t_kind.size(); i++) begin
            cost_total += entry_cost(t_kind[i]);
        end
        cycle_limit = 2 * cost_total;

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_word("reset_tx", 32'd1, {31'd0, tx});
        check_word("reset_pready", 32'd0, {31'd0, pready});

        for (int i = 0; i < t_name.size(); i++) begin
            case (t_kind[i])
                K_APB_WRITE: apb_access(1'b1, t_arg[i][3:0], t_value[i], rd_word);
                K_APB_READ: begin
                    apb_access(1'b0, t_arg[i][3:0], 32'd0, rd_word);
                    if (t_arg[i][3:0] == ADDR_STATUS) begin
                        check_status(t_name[i], uart_status_t'(t_value[i][3:0]),
                                     uart_status_t'(rd_word[3:0]));
                    end
                    check_word(t_name[i], t_value[i], rd_word);
                end
                K_SEND_FRAME:   send_frame(t_arg[i][7:0]);
                K_EXPECT_FRAME: expect_frame(t_name[i], t_value[i][7:0]);
                K_WAIT_STATUS:  wait_status(t_name[i], t_arg[i][3:0], t_value[i][3:0]);
                default:        send_glitch(t_arg[i]);
            endcase
        end

        if (tx_frames.size() != 0) begin
            $display("ERROR: %0d unexpected frames seen on tx", tx_frames.size());
            stop_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: filelist.f
common/uart_pkg.sv
source/baud_tick_gen.sv
source/byte_fifo.sv
uart/uart_apb_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_apb_periph.sv
tests/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
